/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module inst_buffer_tb -f inst_buffer.f --Mdir obj_dir
	./obj_dir/Vinst_buffer_tb | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* inst_buffer.f */
rtl/ibuf_pkg.sv
rtl/ibuf_line_queue.sv
rtl/ibuf_parcel_extract.sv
rtl/ibuf_inst_classify.sv
rtl/ibuf_disp_select.sv
rtl/inst_buffer.sv
test/inst_buffer_props.sv
test/tb_clock_gen.sv
test/inst_buffer_tb.sv

/* rtl/ibuf_disp_select.sv */
`timescale 1ns/1ps

module ibuf_disp_select (
  input  logic                                      i_flush,
  input  ibuf_pkg::slot_t [ibuf_pkg::DISP_SIZE-1:0] i_slots,
  input  ibuf_pkg::inst_cat_t                       i_cats [ibuf_pkg::DISP_SIZE],
  input  logic                                      i_disp_ready,
  output logic                                      o_disp_valid,
  output ibuf_pkg::disp_group_t                     o_disp_group,
  output logic                                      o_fire,
  output logic [ibuf_pkg::USED_W-1:0]               o_used_parcels
);

  ibuf_pkg::disp_group_t           w_group;
  logic [ibuf_pkg::USED_W-1:0]     w_used;

  // ========================================
  // Group cut
  // ========================================
  always_comb begin
    logic                       stop;
    logic                       take;
    logic [ibuf_pkg::CNT_W-1:0] n_arith;
    logic [ibuf_pkg::CNT_W-1:0] n_mem;
    logic [ibuf_pkg::CNT_W-1:0] n_bru;

    stop    = 1'b0;
    n_arith = '0;
    n_mem   = '0;
    n_bru   = '0;
    w_used  = '0;
    w_group = '0;

    for (int k = 0; k < ibuf_pkg::DISP_SIZE; k++) begin
      take = 1'b0;
      if (!stop && i_slots[k].valid) begin
        case (i_cats[k])
          ibuf_pkg::CAT_ARITH:
            take = (n_arith < ibuf_pkg::CNT_W'(ibuf_pkg::ARITH_LIMIT));
          ibuf_pkg::CAT_LD, ibuf_pkg::CAT_ST:
            take = (n_mem < ibuf_pkg::CNT_W'(ibuf_pkg::MEM_LIMIT));
          ibuf_pkg::CAT_BR:
            take = (n_bru < ibuf_pkg::CNT_W'(ibuf_pkg::BRU_LIMIT));
          default:
            take = (k == 0);  // Illegal only leads a group
        endcase
      end

      if (take) begin
        w_group.inst[k].valid  = 1'b1;
        w_group.inst[k].word   = i_slots[k].word;
        w_group.inst[k].is_rvc = i_slots[k].is_rvc;
        w_group.inst[k].pc     = i_slots[k].pc;
        w_group.inst[k].cat    = i_cats[k];
        w_used = w_used + (i_slots[k].is_rvc ? ibuf_pkg::USED_W'(1) : ibuf_pkg::USED_W'(2));

        case (i_cats[k])
          ibuf_pkg::CAT_ARITH: n_arith = n_arith + ibuf_pkg::CNT_W'(1);
          ibuf_pkg::CAT_LD, ibuf_pkg::CAT_ST: n_mem = n_mem + ibuf_pkg::CNT_W'(1);
          ibuf_pkg::CAT_BR: begin
            n_bru = n_bru + ibuf_pkg::CNT_W'(1);
            stop  = 1'b1;   // Nothing after a branch
          end
          default: stop = 1'b1;
        endcase
      end else begin
        stop = 1'b1;
      end
    end

    w_group.arith_cnt = n_arith;
    w_group.mem_cnt   = n_mem;
    w_group.bru_cnt   = n_bru;
  end

  assign o_disp_group   = w_group;
  assign o_disp_valid   = w_group.inst[0].valid & !i_flush;
  assign o_fire         = o_disp_valid & i_disp_ready;
  assign o_used_parcels = w_used;

endmodule

/* rtl/ibuf_inst_classify.sv */
`timescale 1ns/1ps

module ibuf_inst_classify (
  input  ibuf_pkg::slot_t [ibuf_pkg::DISP_SIZE-1:0] i_slots,
  output ibuf_pkg::inst_cat_t                       o_cats [ibuf_pkg::DISP_SIZE]
);

  always_comb begin
    ibuf_pkg::inst_word_u w;

    for (int k = 0; k < ibuf_pkg::DISP_SIZE; k++) begin
      w = i_slots[k].word;
      if (w.rvc.quadrant == 2'b11) begin
        case (w.rv32.opcode)
          7'b0110011, 7'b0010011: o_cats[k] = ibuf_pkg::CAT_ARITH;  // OP, OP-IMM
          7'b0110111, 7'b0010111: o_cats[k] = ibuf_pkg::CAT_ARITH;  // LUI, AUIPC
          7'b0000011:             o_cats[k] = ibuf_pkg::CAT_LD;
          7'b0100011:             o_cats[k] = ibuf_pkg::CAT_ST;
          7'b1100011, 7'b1101111, 7'b1100111: o_cats[k] = ibuf_pkg::CAT_BR;
          default:                o_cats[k] = ibuf_pkg::CAT_ILLEGAL;
        endcase
      end else begin
        // Compressed, by quadrant then funct3
        o_cats[k] = ibuf_pkg::CAT_ARITH;
        case (w.rvc.quadrant)
          2'b00: begin
            if ({w.rvc.funct3, w.rvc.mid, w.rvc.rs2} == '0) begin
              o_cats[k] = ibuf_pkg::CAT_ILLEGAL;
            end else if (w.rvc.funct3 == 3'b010) begin
              o_cats[k] = ibuf_pkg::CAT_LD;   // C.LW
            end else if (w.rvc.funct3 == 3'b110) begin
              o_cats[k] = ibuf_pkg::CAT_ST;   // C.SW
            end
          end
          2'b01: begin
            if (w.rvc.funct3 inside {3'b001, 3'b101, 3'b110, 3'b111}) begin
              o_cats[k] = ibuf_pkg::CAT_BR;   // C.JAL, C.J, C.BEQZ, C.BNEZ
            end
          end
          default: begin
            if (w.rvc.funct3 == 3'b010) begin
              o_cats[k] = ibuf_pkg::CAT_LD;   // C.LWSP
            end else if (w.rvc.funct3 == 3'b110) begin
              o_cats[k] = ibuf_pkg::CAT_ST;   // C.SWSP
            end else if ((w.rvc.funct3 == 3'b100) && (w.rvc.rs2 == '0) &&
                         (w.rvc.mid[4:0] != '0)) begin
              o_cats[k] = ibuf_pkg::CAT_BR;   // C.JR, C.JALR
            end
          end
        endcase
      end
    end
  end

endmodule

/* rtl/ibuf_line_queue.sv */
`timescale 1ns/1ps

module ibuf_line_queue (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_flush,
  input  logic                  i_push,
  input  ibuf_pkg::fetch_line_t i_line,
  input  logic                  i_pop,
  output logic                  o_full,
  output ibuf_pkg::fetch_line_t o_head,
  output logic                  o_head_valid,
  output ibuf_pkg::fetch_line_t o_next,
  output logic                  o_next_valid
);

  ibuf_pkg::fetch_line_t                 r_lines [ibuf_pkg::QUEUE_DEPTH];
  logic [ibuf_pkg::QUEUE_DEPTH-1:0]      r_valid;
  logic [ibuf_pkg::PTR_W-1:0]            r_inptr;
  logic [ibuf_pkg::PTR_W-1:0]            r_outptr;
  logic [ibuf_pkg::QCNT_W-1:0]           r_count;
  logic [ibuf_pkg::PTR_W-1:0]            w_outptr_p1;

  assign w_outptr_p1 = r_outptr + ibuf_pkg::PTR_W'(1);  // Wraps at depth

  // Line payload
  always_ff @(posedge i_clk) begin
    if (i_push) begin
      r_lines[r_inptr] <= i_line;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= '0;
      r_inptr  <= '0;
      r_outptr <= '0;
      r_count  <= '0;
    end else if (i_flush) begin
      r_valid  <= '0;
      r_inptr  <= '0;
      r_outptr <= '0;
      r_count  <= '0;
    end else begin
      if (i_pop) begin
        r_valid[r_outptr] <= 1'b0;
        r_outptr          <= w_outptr_p1;
      end
      if (i_push) begin
        r_valid[r_inptr] <= 1'b1;
        r_inptr          <= r_inptr + ibuf_pkg::PTR_W'(1);
      end
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + ibuf_pkg::QCNT_W'(1);
        2'b01:   r_count <= r_count - ibuf_pkg::QCNT_W'(1);
        default: r_count <= r_count;  // Both or neither
      endcase
    end
  end

  assign o_full       = (r_count == ibuf_pkg::QCNT_W'(ibuf_pkg::QUEUE_DEPTH));
  assign o_head       = r_lines[r_outptr];
  assign o_head_valid = r_valid[r_outptr];
  assign o_next       = r_lines[w_outptr_p1];
  assign o_next_valid = r_valid[w_outptr_p1];

endmodule

/* rtl/ibuf_parcel_extract.sv */
`timescale 1ns/1ps

module ibuf_parcel_extract (
  input  logic                                          i_clk,
  input  logic                                          i_reset_n,
  input  logic                                          i_flush,
  input  ibuf_pkg::fetch_line_t                         i_head,
  input  logic                                          i_head_valid,
  input  ibuf_pkg::fetch_line_t                         i_next,
  input  logic                                          i_next_valid,
  input  logic                                          i_fire,
  input  logic [ibuf_pkg::USED_W-1:0]                   i_used_parcels,
  output ibuf_pkg::slot_t [ibuf_pkg::DISP_SIZE-1:0]     o_slots,
  output logic                                          o_pop
);

  logic [ibuf_pkg::POS_W-1:0]   r_pos;       // Offset past the PC start parcel
  logic [ibuf_pkg::IDX_W-1:0]   w_start;
  logic [ibuf_pkg::IDX_W-1:0]   w_end;
  logic [ibuf_pkg::VADDR_W-1:0] w_base_pc;

  assign w_start   = ibuf_pkg::IDX_W'(r_pos) +
                     ibuf_pkg::IDX_W'(i_head.pc[ibuf_pkg::POS_W:1]);
  assign w_end     = w_start + ibuf_pkg::IDX_W'(i_used_parcels);
  assign w_base_pc = {i_head.pc[ibuf_pkg::VADDR_W-1:ibuf_pkg::POS_W+1],
                      {(ibuf_pkg::POS_W+1){1'b0}}};

  // Head line is done once the walk reaches the next line
  assign o_pop = i_fire & (|w_end[ibuf_pkg::IDX_W-1:ibuf_pkg::POS_W]);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_pos <= '0;
    end else if (i_flush) begin
      r_pos <= '0;
    end else if (o_pop) begin
      r_pos <= w_end[ibuf_pkg::POS_W-1:0];  // Excess carries over
    end else if (i_fire) begin
      r_pos <= r_pos + i_used_parcels[ibuf_pkg::POS_W-1:0];
    end
  end

  // ========================================
  // Parcel walk
  // ========================================
  always_comb begin
    logic [ibuf_pkg::IDX_W-1:0] p0;
    logic [ibuf_pkg::IDX_W-1:0] p1;
    logic [15:0]                lo;
    logic [15:0]                hi;
    logic                       lo_ok;
    logic                       hi_ok;
    logic                       rvc;

    p0 = w_start;
    for (int k = 0; k < ibuf_pkg::DISP_SIZE; k++) begin
      p1 = p0 + ibuf_pkg::IDX_W'(1);

      // Top index bit set means beyond the next line
      lo_ok = !p0[ibuf_pkg::POS_W+1] & (p0[ibuf_pkg::POS_W] ? i_next_valid : i_head_valid);
      hi_ok = !p1[ibuf_pkg::POS_W+1] & (p1[ibuf_pkg::POS_W] ? i_next_valid : i_head_valid);
      lo    = p0[ibuf_pkg::POS_W] ? i_next.data[{p0[ibuf_pkg::POS_W-1:0], 4'h0} +: 16] :
                                    i_head.data[{p0[ibuf_pkg::POS_W-1:0], 4'h0} +: 16];
      hi    = p1[ibuf_pkg::POS_W] ? i_next.data[{p1[ibuf_pkg::POS_W-1:0], 4'h0} +: 16] :
                                    i_head.data[{p1[ibuf_pkg::POS_W-1:0], 4'h0} +: 16];
      rvc   = (lo[1:0] != 2'b11);

      o_slots[k].valid  = lo_ok & (rvc | hi_ok);
      o_slots[k].is_rvc = rvc;
      o_slots[k].word   = rvc ? {16'h0000, lo} : {hi, lo};
      o_slots[k].pc     = w_base_pc + ibuf_pkg::VADDR_W'({p0, 1'b0});

      p0 = rvc ? p1 : p0 + ibuf_pkg::IDX_W'(2);
    end
  end

endmodule

/* rtl/ibuf_pkg.sv */
package ibuf_pkg;

  // ========================================
  // Sizes and dispatch limits
  // ========================================
  localparam int VADDR_W     = 32;
  localparam int LINE_W      = 64;
  localparam int PARCELS     = LINE_W / 16;
  localparam int POS_W       = $clog2(PARCELS);
  localparam int IDX_W       = POS_W + 2;          // Covers head and next line, plus overrun
  localparam int DISP_SIZE   = 3;
  localparam int QUEUE_DEPTH = 4;
  localparam int PTR_W       = $clog2(QUEUE_DEPTH);
  localparam int QCNT_W      = PTR_W + 1;
  localparam int USED_W      = $clog2(2 * DISP_SIZE + 1);
  localparam int CNT_W       = 2;

  localparam int ARITH_LIMIT = 2;
  localparam int MEM_LIMIT   = 1;  // Loads and stores together
  localparam int BRU_LIMIT   = 1;

  typedef enum logic [2:0] {
    CAT_ARITH,
    CAT_LD,
    CAT_ST,
    CAT_BR,
    CAT_ILLEGAL
  } inst_cat_t;

  // ========================================
  // Instruction word views
  // ========================================
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv32_fields_t;

  typedef struct packed {
    logic [15:0] upper;     // Zero for compressed words
    logic [2:0]  funct3;
    logic [5:0]  mid;       // Bit 12, then rd/rs1
    logic [4:0]  rs2;
    logic [1:0]  quadrant;
  } rvc_fields_t;

  typedef union packed {
    rv32_fields_t rv32;
    rvc_fields_t  rvc;
  } inst_word_u;

  // ========================================
  // Port bundles
  // ========================================
  typedef struct packed {
    logic [VADDR_W-1:0] pc;
    logic [LINE_W-1:0]  data;
  } fetch_line_t;

  typedef struct packed {
    logic               valid;
    inst_word_u         word;
    logic               is_rvc;
    logic [VADDR_W-1:0] pc;
  } slot_t;

  typedef struct packed {
    logic               valid;
    inst_word_u         word;
    logic               is_rvc;
    logic [VADDR_W-1:0] pc;
    inst_cat_t          cat;
  } disp_inst_t;

  typedef struct packed {
    disp_inst_t [DISP_SIZE-1:0] inst;
    logic [CNT_W-1:0]           arith_cnt;
    logic [CNT_W-1:0]           mem_cnt;
    logic [CNT_W-1:0]           bru_cnt;
  } disp_group_t;

endpackage

/* rtl/inst_buffer.sv */
`timescale 1ns/1ps

module inst_buffer (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_flush,
  input  logic                  i_fetch_valid,
  input  ibuf_pkg::fetch_line_t i_fetch_line,
  output logic                  o_fetch_ready,
  output logic                  o_disp_valid,
  output ibuf_pkg::disp_group_t o_disp_group,
  input  logic                  i_disp_ready
);

  logic                                      w_full;
  logic                                      w_push;
  logic                                      w_pop;
  logic                                      w_fire;
  ibuf_pkg::fetch_line_t                     w_head;
  logic                                      w_head_valid;
  ibuf_pkg::fetch_line_t                     w_next;
  logic                                      w_next_valid;
  ibuf_pkg::slot_t [ibuf_pkg::DISP_SIZE-1:0] w_slots;
  ibuf_pkg::inst_cat_t                       w_cats [ibuf_pkg::DISP_SIZE];
  logic [ibuf_pkg::USED_W-1:0]               w_used_parcels;

  assign o_fetch_ready = !w_full;
  assign w_push        = i_fetch_valid & !w_full;

  ibuf_line_queue u_queue (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (i_flush),
    .i_push       (w_push),
    .i_line       (i_fetch_line),
    .i_pop        (w_pop),
    .o_full       (w_full),
    .o_head       (w_head),
    .o_head_valid (w_head_valid),
    .o_next       (w_next),
    .o_next_valid (w_next_valid)
  );

  ibuf_parcel_extract u_extract (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_flush        (i_flush),
    .i_head         (w_head),
    .i_head_valid   (w_head_valid),
    .i_next         (w_next),
    .i_next_valid   (w_next_valid),
    .i_fire         (w_fire),
    .i_used_parcels (w_used_parcels),
    .o_slots        (w_slots),
    .o_pop          (w_pop)
  );

  ibuf_inst_classify u_classify (
    .i_slots (w_slots),
    .o_cats  (w_cats)
  );

  ibuf_disp_select u_select (
    .i_flush        (i_flush),
    .i_slots        (w_slots),
    .i_cats         (w_cats),
    .i_disp_ready   (i_disp_ready),
    .o_disp_valid   (o_disp_valid),
    .o_disp_group   (o_disp_group),
    .o_fire         (w_fire),
    .o_used_parcels (w_used_parcels)
  );

endmodule

/* test/inst_buffer_props.sv */
`timescale 1ns/1ps

module inst_buffer_props (
  input logic                  i_clk,
  input logic                  i_reset_n,
  input logic                  i_flush,
  input logic                  i_push,
  input logic                  i_pop,
  input logic                  i_fetch_ready,
  input logic                  i_disp_valid,
  input logic                  i_disp_ready,
  input ibuf_pkg::disp_group_t i_disp_group
);

  logic [2:0] r_count;  // Shadow of the queue fill level

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_count <= '0;
    end else if (i_flush) begin
      r_count <= '0;
    end else begin
      r_count <= r_count + 3'(i_push) - 3'(i_pop);
    end
  end

  a_flush_clears_valid: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) i_flush |=> !i_disp_valid
  ) else $error("dispatch valid seen in the cycle after a flush");

  // Fetch may still extend a partial group, so pushes are exempt
  a_group_holds: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (i_disp_valid && !i_disp_ready && !i_flush && !i_push) |=>
      (i_flush || $stable(i_disp_group))
  ) else $error("dispatch group changed under back-pressure");

  a_ready_vs_fill: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_fetch_ready == (r_count != 3'(ibuf_pkg::QUEUE_DEPTH))
  ) else $error("fetch ready does not match the queue fill level");

endmodule

bind inst_buffer inst_buffer_props u_props (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_flush       (i_flush),
  .i_push        (w_push),
  .i_pop         (w_pop),
  .i_fetch_ready (o_fetch_ready),
  .i_disp_valid  (o_disp_valid),
  .i_disp_ready  (i_disp_ready),
  .i_disp_group  (o_disp_group)
);

/* test/inst_buffer_tb.sv */
`timescale 1ns/1ps

module inst_buffer_tb;

  localparam int CYCLE_LIMIT = 400;

  logic                  clk;
  logic                  reset_n;
  logic                  flush;
  logic                  fetch_valid;
  ibuf_pkg::fetch_line_t fetch_line;
  logic                  fetch_ready;
  logic                  disp_valid;
  ibuf_pkg::disp_group_t disp_group;
  logic                  disp_ready;
  ibuf_pkg::disp_inst_t  no_inst;
  int                    cycle_count;

  tb_clock_gen u_clk (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  inst_buffer uut (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_flush       (flush),
    .i_fetch_valid (fetch_valid),
    .i_fetch_line  (fetch_line),
    .o_fetch_ready (fetch_ready),
    .o_disp_valid  (disp_valid),
    .o_disp_group  (disp_group),
    .i_disp_ready  (disp_ready)
  );

  // ========================================
  // Reporting and compare tasks
  // ========================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_inst(input string name, input ibuf_pkg::disp_inst_t got,
                            input ibuf_pkg::disp_inst_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      abort_run("dispatch slot mismatch");
    end
  endtask

  task automatic check_cnt(input string name, input logic [ibuf_pkg::CNT_W-1:0] got,
                           input logic [ibuf_pkg::CNT_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      abort_run("resource count mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      abort_run("handshake level mismatch");
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      abort_run("Timeout: the tests did not finish within the cycle limit");
    end
  end

  // ========================================
  // Stimulus helpers
  // ========================================
  function automatic logic [31:0] addi(input logic [4:0] rd, input logic [11:0] imm);
    return {imm, 5'd0, 3'b000, rd, 7'b0010011};
  endfunction

  // Low bits other than 11 mark a compressed parcel
  function automatic ibuf_pkg::disp_inst_t exp_inst(input logic [31:0] word,
                                                    input logic [31:0] pc,
                                                    input ibuf_pkg::inst_cat_t cat);
    ibuf_pkg::disp_inst_t e;
    e        = '0;
    e.valid  = 1'b1;
    e.is_rvc = (word[1:0] != 2'b11);
    e.word   = e.is_rvc ? {16'h0000, word[15:0]} : word;
    e.pc     = pc;
    e.cat    = cat;
    return e;
  endfunction

  task automatic push_line(input logic [31:0] pc, input logic [63:0] data);
    fetch_line.pc   = pc;
    fetch_line.data = data;
    fetch_valid     = 1'b1;
    while (!fetch_ready) @(negedge clk);
    @(negedge clk);
    fetch_valid = 1'b0;
  endtask

  task automatic take_group(input ibuf_pkg::disp_inst_t e0, input ibuf_pkg::disp_inst_t e1,
                            input ibuf_pkg::disp_inst_t e2, input logic [1:0] n_arith,
                            input logic [1:0] n_mem, input logic [1:0] n_bru);
    while (!disp_valid) @(negedge clk);
    check_inst("o_disp_group.inst[0]", disp_group.inst[0], e0);
    check_inst("o_disp_group.inst[1]", disp_group.inst[1], e1);
    check_inst("o_disp_group.inst[2]", disp_group.inst[2], e2);
    check_cnt("o_disp_group.arith_cnt", disp_group.arith_cnt, n_arith);
    check_cnt("o_disp_group.mem_cnt", disp_group.mem_cnt, n_mem);
    check_cnt("o_disp_group.bru_cnt", disp_group.bru_cnt, n_bru);
    disp_ready = 1'b1;
    @(negedge clk);
    disp_ready = 1'b0;
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic test_reset_levels();
    check_bit("o_disp_valid", disp_valid, 1'b0);
    check_bit("o_fetch_ready", fetch_ready, 1'b1);
  endtask

  task automatic test_arith_pairs();
    push_line(32'h1000, {addi(5'd2, 12'd2), addi(5'd1, 12'd1)});
    push_line(32'h1008, {addi(5'd4, 12'd4), addi(5'd3, 12'd3)});
    take_group(exp_inst(addi(5'd1, 12'd1), 32'h1000, ibuf_pkg::CAT_ARITH),
               exp_inst(addi(5'd2, 12'd2), 32'h1004, ibuf_pkg::CAT_ARITH),
               no_inst, 2'd2, 2'd0, 2'd0);
    take_group(exp_inst(addi(5'd3, 12'd3), 32'h1008, ibuf_pkg::CAT_ARITH),
               exp_inst(addi(5'd4, 12'd4), 32'h100c, ibuf_pkg::CAT_ARITH),
               no_inst, 2'd2, 2'd0, 2'd0);
    check_bit("o_disp_valid", disp_valid, 1'b0);
  endtask

  task automatic test_straddle();
    push_line(32'h2000, {16'h0293, 16'h018d, 16'h0109, 16'h0085});
    take_group(exp_inst(32'h0085, 32'h2000, ibuf_pkg::CAT_ARITH),
               exp_inst(32'h0109, 32'h2002, ibuf_pkg::CAT_ARITH),
               no_inst, 2'd2, 2'd0, 2'd0);
    take_group(exp_inst(32'h018d, 32'h2004, ibuf_pkg::CAT_ARITH),
               no_inst, no_inst, 2'd1, 2'd0, 2'd0);
    check_bit("o_disp_valid", disp_valid, 1'b0);  // Upper half not fetched yet
    push_line(32'h2008, {16'h0001, 16'h0001, 16'h0085, 16'h0050});
    take_group(exp_inst(32'h0050_0293, 32'h2006, ibuf_pkg::CAT_ARITH),
               exp_inst(32'h0085, 32'h200a, ibuf_pkg::CAT_ARITH),
               no_inst, 2'd2, 2'd0, 2'd0);
    take_group(exp_inst(32'h0001, 32'h200c, ibuf_pkg::CAT_ARITH),
               exp_inst(32'h0001, 32'h200e, ibuf_pkg::CAT_ARITH),
               no_inst, 2'd2, 2'd0, 2'd0);
  endtask

  task automatic test_category_limits();
    push_line(32'h3000, {32'h0050_a223, 32'h0000_a283});   // SW, LW
    push_line(32'h3008, {16'h0085, 16'ha001, addi(5'd7, 12'd7)});
    push_line(32'h3010, {16'h0085, 16'h0000, 16'h0085, 16'h8082});
    take_group(exp_inst(32'h0000_a283, 32'h3000, ibuf_pkg::CAT_LD),
               no_inst, no_inst, 2'd0, 2'd1, 2'd0);
    take_group(exp_inst(32'h0050_a223, 32'h3004, ibuf_pkg::CAT_ST),
               exp_inst(addi(5'd7, 12'd7), 32'h3008, ibuf_pkg::CAT_ARITH),
               exp_inst(32'ha001, 32'h300c, ibuf_pkg::CAT_BR),
               2'd1, 2'd1, 2'd1);
    take_group(exp_inst(32'h0085, 32'h300e, ibuf_pkg::CAT_ARITH),
               exp_inst(32'h8082, 32'h3010, ibuf_pkg::CAT_BR),
               no_inst, 2'd1, 2'd0, 2'd1);
    take_group(exp_inst(32'h0085, 32'h3012, ibuf_pkg::CAT_ARITH),
               no_inst, no_inst, 2'd1, 2'd0, 2'd0);
    take_group(exp_inst(32'h0000, 32'h3014, ibuf_pkg::CAT_ILLEGAL),
               no_inst, no_inst, 2'd0, 2'd0, 2'd0);
    take_group(exp_inst(32'h0085, 32'h3016, ibuf_pkg::CAT_ARITH),
               no_inst, no_inst, 2'd1, 2'd0, 2'd0);
  endtask

  task automatic test_backpressure();
    for (int i = 0; i < 4; i++) begin
      push_line(32'h4000 + 32'(8 * i),
                {addi(5'(2 * i + 2), 12'(2 * i + 21)), addi(5'(2 * i + 1), 12'(2 * i + 20))});
    end
    check_bit("o_fetch_ready", fetch_ready, 1'b0);
    for (int i = 0; i < 4; i++) begin
      take_group(exp_inst(addi(5'(2 * i + 1), 12'(2 * i + 20)), 32'h4000 + 32'(8 * i),
                          ibuf_pkg::CAT_ARITH),
                 exp_inst(addi(5'(2 * i + 2), 12'(2 * i + 21)), 32'h4004 + 32'(8 * i),
                          ibuf_pkg::CAT_ARITH),
                 no_inst, 2'd2, 2'd0, 2'd0);
      check_bit("o_fetch_ready", fetch_ready, 1'b1);
    end
  endtask

  task automatic test_offset_and_flush();
    push_line(32'h5004, {addi(5'd1, 12'd101), 16'h2222, 16'h1111});
    push_line(32'h5008, {addi(5'd3, 12'd103), addi(5'd2, 12'd102)});
    take_group(exp_inst(addi(5'd1, 12'd101), 32'h5004, ibuf_pkg::CAT_ARITH),
               exp_inst(addi(5'd2, 12'd102), 32'h5008, ibuf_pkg::CAT_ARITH),
               no_inst, 2'd2, 2'd0, 2'd0);
    push_line(32'h6000, {addi(5'd5, 12'd105), addi(5'd4, 12'd104)});
    flush = 1'b1;
    #1;
    check_bit("o_disp_valid", disp_valid, 1'b0);  // Masked in the flush cycle
    @(negedge clk);
    flush = 1'b0;
    #1;
    check_bit("o_disp_valid", disp_valid, 1'b0);
    check_bit("o_fetch_ready", fetch_ready, 1'b1);
    @(negedge clk);
    push_line(32'h7000, {addi(5'd7, 12'd107), addi(5'd6, 12'd106)});
    take_group(exp_inst(addi(5'd6, 12'd106), 32'h7000, ibuf_pkg::CAT_ARITH),
               exp_inst(addi(5'd7, 12'd107), 32'h7004, ibuf_pkg::CAT_ARITH),
               no_inst, 2'd2, 2'd0, 2'd0);
  endtask

  initial begin
    flush       = 1'b0;
    fetch_valid = 1'b0;
    fetch_line  = '0;
    disp_ready  = 1'b0;
    no_inst     = '0;
    cycle_count = 0;
    @(posedge reset_n);
    @(negedge clk);
    test_reset_levels();
    test_arith_pairs();
    test_straddle();
    test_category_limits();
    test_backpressure();
    test_offset_and_flush();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;  // 10 ns period
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (3) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule
